/* Makefile */
# Verilator build and run of the HDMI transmitter configuration sequencer

VERILATOR ?= verilator
TOP       ?= tb_adv7513_ctrl
DUT_TOP   ?= adv7513_ctrl
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# pass or fail comes from the log, not from the exit code of the pipe
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* adv7513_ctrl.sv */
`timescale 1ns/1ns

module adv7513_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       hdmi_int,
    input  logic                       vsync,
    input  adv_bus_pkg::reg_data_t     cfg_reg_17,
    input  adv_bus_pkg::reg_data_t     cfg_reg_3b,
    input  adv_bus_pkg::reg_data_t     cfg_reg_3c,
    output adv_bus_pkg::chip_addr_t    i2c_chip_addr,
    output adv_bus_pkg::reg_addr_t     i2c_reg_addr,
    output adv_bus_pkg::reg_data_t     i2c_value,
    output logic                       i2c_is_read,
    output logic                       i2c_enable,
    input  logic                       i2c_done,
    input  adv_bus_pkg::reg_data_t     i2c_data,
    input  logic                       i2c_ack_error,
    output logic                       ready,
    output adv_bus_pkg::reg_data_t     chip_revision,
    output adv_bus_pkg::reg_data_t     id_check_high,
    output adv_bus_pkg::reg_data_t     id_check_low,
    output adv_bus_pkg::reg_data_t     pll_status,
    output adv_bus_pkg::reg_data_t     vic_detected,
    output adv_bus_pkg::reg_data_t     vic_to_rx,
    output adv_bus_pkg::reg_data_t     misc_data,
    output adv_seq_pkg::err_count_t    pll_errors,
    output adv_seq_pkg::frame_count_t  frame_count
);

    adv_seq_pkg::phase_t    phase;
    adv_seq_pkg::step_t     step;
    adv_seq_pkg::step_t     capture_step;
    adv_bus_pkg::reg_addr_t reg_addr;
    adv_bus_pkg::reg_data_t reg_value;
    logic                   is_read;
    logic                   last_step;
    logic                   capture_en;
    logic                   pll_fail;
    logic                   frame_tick;

    adv_seq_ctrl u_seq_ctrl (
        .clk           (clk),
        .reset         (reset),
        .hdmi_int      (hdmi_int),
        .vsync         (vsync),
        .i2c_done      (i2c_done),
        .i2c_ack_error (i2c_ack_error),
        .i2c_data      (i2c_data),
        .reg_addr      (reg_addr),
        .reg_value     (reg_value),
        .is_read       (is_read),
        .last_step     (last_step),
        .phase         (phase),
        .step          (step),
        .i2c_chip_addr (i2c_chip_addr),
        .i2c_reg_addr  (i2c_reg_addr),
        .i2c_value     (i2c_value),
        .i2c_is_read   (i2c_is_read),
        .i2c_enable    (i2c_enable),
        .ready         (ready),
        .capture_en    (capture_en),
        .capture_step  (capture_step),
        .pll_fail      (pll_fail),
        .frame_tick    (frame_tick)
    );

    adv_init_rom u_init_rom (
        .phase      (phase),
        .step       (step),
        .cfg_reg_17 (cfg_reg_17),
        .cfg_reg_3b (cfg_reg_3b),
        .cfg_reg_3c (cfg_reg_3c),
        .reg_addr   (reg_addr),
        .reg_value  (reg_value),
        .is_read    (is_read),
        .last_step  (last_step)
    );

    adv_status_regs u_status_regs (
        .clk           (clk),
        .reset         (reset),
        .capture_en    (capture_en),
        .capture_step  (capture_step),
        .i2c_data      (i2c_data),
        .pll_fail      (pll_fail),
        .frame_tick    (frame_tick),
        .chip_revision (chip_revision),
        .id_check_high (id_check_high),
        .id_check_low  (id_check_low),
        .pll_status    (pll_status),
        .vic_detected  (vic_detected),
        .vic_to_rx     (vic_to_rx),
        .misc_data     (misc_data),
        .pll_errors    (pll_errors),
        .frame_count   (frame_count)
    );

endmodule

/* adv_bus_pkg.sv */
package adv_bus_pkg;

    // 7-bit device address as sent on the two-wire bus
    typedef logic [6:0] chip_addr_t;

    // register index inside the transmitter
    typedef logic [7:0] reg_addr_t;

    // one register byte, written or read back
    typedef logic [7:0] reg_data_t;

    // transmitter main map address with the PD pin tied low
    localparam chip_addr_t CHIP_ADDR = 7'h39;

endpackage

/* adv_init_rom.sv */
`timescale 1ns/1ns

module adv_init_rom (
    input  adv_seq_pkg::phase_t    phase,
    input  adv_seq_pkg::step_t     step,
    input  adv_bus_pkg::reg_data_t cfg_reg_17,
    input  adv_bus_pkg::reg_data_t cfg_reg_3b,
    input  adv_bus_pkg::reg_data_t cfg_reg_3c,
    output adv_bus_pkg::reg_addr_t reg_addr,
    output adv_bus_pkg::reg_data_t reg_value,
    output logic                   is_read,
    output logic                   last_step
);

    // register address in the upper byte, value in the lower byte
    logic [15:0] entry;

    assign reg_addr  = entry[15:8];
    assign reg_value = entry[7:0];

    always_comb begin
        entry     = 16'h0000;
        is_read   = 1'b0;
        last_step = 1'b0;
        case (phase)
            adv_seq_pkg::ph_bootstrap: begin
                case (step)
                    // power up, then the fixed values from the programming guide
                    5'd0:    entry = 16'h4110;
                    5'd1:    entry = 16'h9803;
                    5'd2:    entry = 16'h9AE0;
                    5'd3:    entry = 16'h9C30;
                    5'd4:    entry = 16'h9D01;
                    5'd5:    entry = 16'hA2A4;
                    5'd6:    entry = 16'hA3A4;
                    5'd7:    entry = 16'hE0D0;
                    5'd8:    entry = 16'hF900;
                    // enable hpd and monitor sense interrupts, then clear them
                    5'd9:    entry = 16'h94C0;
                    5'd10:   entry = 16'h96C0;
                    default: last_step = 1'b1;
                endcase
            end
            adv_seq_pkg::ph_link_down: begin
                case (step)
                    5'd0:    entry = 16'h4110;
                    5'd1:    entry = 16'hD610;
                    5'd2:    entry = 16'hA13C;
                    default: last_step = 1'b1;
                endcase
            end
            adv_seq_pkg::ph_init: begin
                case (step)
                    5'd0:    entry = 16'h1500;
                    // sync polarity and aspect ratio come from the video config
                    5'd1:    entry = {8'h17, cfg_reg_17};
                    5'd2:    entry = {8'h16, 8'h30 | adv_seq_pkg::OUTPUT_FMT};
                    5'd3:    entry = 16'h5500;
                    5'd4:    entry = 16'h1846;
                    // hdmi mode, no hdcp
                    5'd5:    entry = 16'hAF06;
                    5'd6:    entry = 16'hBA60;
                    // audio: i2s, automatic cts, n = 0x01880 for 44.1 khz
                    5'd7:    entry = 16'h0A00;
                    5'd8:    entry = 16'h0100;
                    5'd9:    entry = 16'h0218;
                    5'd10:   entry = 16'h0380;
                    5'd11:   entry = 16'h0B0E;
                    5'd12:   entry = 16'h0C05;
                    5'd13:   entry = 16'h0D10;
                    // pixel repetition and vic, again from the video config
                    5'd14:   entry = {8'h3B, cfg_reg_3b};
                    5'd15:   entry = {8'h3C, cfg_reg_3c};
                    default: last_step = 1'b1;
                endcase
            end
            adv_seq_pkg::ph_link_up: begin
                case (step)
                    5'd0:    entry = 16'hA100;
                    5'd1:    entry = 16'hD600;
                    default: last_step = 1'b1;
                endcase
            end
            adv_seq_pkg::ph_pll_check: begin
                // read on the even step, evaluate on the odd one
                is_read   = 1'b1;
                entry     = {adv_seq_pkg::REG_PLL_STATUS, 8'h00};
                last_step = (step >= 5'd2);
            end
            adv_seq_pkg::ph_debug: begin
                is_read   = 1'b1;
                last_step = (step >= 5'd14);
                case (step[4:1])
                    4'd0:    entry = {adv_seq_pkg::REG_CHIP_REV, 8'h00};
                    4'd1:    entry = {adv_seq_pkg::REG_ID_HIGH, 8'h00};
                    4'd2:    entry = {adv_seq_pkg::REG_ID_LOW, 8'h00};
                    4'd3:    entry = {adv_seq_pkg::REG_PLL_STATUS, 8'h00};
                    4'd4:    entry = {adv_seq_pkg::REG_VIC_DETECTED, 8'h00};
                    4'd5:    entry = {adv_seq_pkg::REG_VIC_TO_RX, 8'h00};
                    default: entry = {adv_seq_pkg::REG_MISC, 8'h00};
                endcase
            end
            default: last_step = 1'b1;
        endcase
    end

endmodule

/* adv_seq_ctrl.sv */
`timescale 1ns/1ns

module adv_seq_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     hdmi_int,
    input  logic                     vsync,
    input  logic                     i2c_done,
    input  logic                     i2c_ack_error,
    input  adv_bus_pkg::reg_data_t   i2c_data,
    input  adv_bus_pkg::reg_addr_t   reg_addr,
    input  adv_bus_pkg::reg_data_t   reg_value,
    input  logic                     is_read,
    input  logic                     last_step,
    output adv_seq_pkg::phase_t      phase,
    output adv_seq_pkg::step_t       step,
    output adv_bus_pkg::chip_addr_t  i2c_chip_addr,
    output adv_bus_pkg::reg_addr_t   i2c_reg_addr,
    output adv_bus_pkg::reg_data_t   i2c_value,
    output logic                     i2c_is_read,
    output logic                     i2c_enable,
    output logic                     ready,
    output logic                     capture_en,
    output adv_seq_pkg::step_t       capture_step,
    output logic                     pll_fail,
    output logic                     frame_tick
);

    adv_seq_pkg::state_t state;
    logic                vsync_q;
    logic                pll_locked;

    // only one device on this bus
    assign i2c_chip_addr = adv_bus_pkg::CHIP_ADDR;
    assign pll_locked    = i2c_data[adv_seq_pkg::PLL_LOCK_BIT];

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= adv_seq_pkg::st_issue;
            phase      <= adv_seq_pkg::ph_bootstrap;
            step       <= '0;
            i2c_enable <= 1'b0;
            ready      <= 1'b0;
            capture_en <= 1'b0;
            pll_fail   <= 1'b0;
            frame_tick <= 1'b0;
            vsync_q    <= 1'b0;
        end else begin
            vsync_q    <= vsync;
            capture_en <= 1'b0;
            pll_fail   <= 1'b0;
            frame_tick <= 1'b0;
            case (state)
                adv_seq_pkg::st_issue: begin
                    if (i2c_done) begin
                        if (last_step) begin
                            // phase finished, one cycle without a request
                            step <= '0;
                            case (phase)
                                adv_seq_pkg::ph_bootstrap: phase <= adv_seq_pkg::ph_link_down;
                                adv_seq_pkg::ph_link_down: phase <= adv_seq_pkg::ph_init;
                                adv_seq_pkg::ph_init:      phase <= adv_seq_pkg::ph_pll_check;
                                adv_seq_pkg::ph_pll_check: phase <= adv_seq_pkg::ph_link_up;
                                default: begin
                                    phase <= adv_seq_pkg::ph_ready;
                                    state <= adv_seq_pkg::st_idle;
                                    ready <= 1'b1;
                                end
                            endcase
                        end else if (is_read && step[0]) begin
                            // evaluate the byte of the read that just completed
                            step <= step + 5'd1;
                            if (reg_addr == adv_seq_pkg::REG_PLL_STATUS && !pll_locked) begin
                                pll_fail <= 1'b1;
                            end
                            if (phase == adv_seq_pkg::ph_pll_check && !pll_locked) begin
                                phase <= adv_seq_pkg::ph_bootstrap;
                                step  <= '0;
                            end
                            if (phase == adv_seq_pkg::ph_debug) begin
                                capture_en   <= 1'b1;
                                capture_step <= {1'b0, step[4:1]};
                            end
                        end else begin
                            i2c_reg_addr <= reg_addr;
                            i2c_value    <= reg_value;
                            i2c_is_read  <= is_read;
                            i2c_enable   <= 1'b1;
                            state        <= adv_seq_pkg::st_wait_1;
                        end
                    end
                end
                adv_seq_pkg::st_wait_1: begin
                    state <= adv_seq_pkg::st_wait_2;
                end
                adv_seq_pkg::st_wait_2: begin
                    i2c_enable <= 1'b0;
                    if (i2c_done) begin
                        // on an ack error the same step goes out again
                        if (!i2c_ack_error) begin
                            step <= step + 5'd1;
                        end
                        state <= adv_seq_pkg::st_issue;
                    end
                end
                default: begin
                    if (!hdmi_int) begin
                        // hot plug or monitor sense event, configure from scratch
                        ready <= 1'b0;
                        phase <= adv_seq_pkg::ph_bootstrap;
                        step  <= '0;
                        state <= adv_seq_pkg::st_issue;
                    end else if (ready && vsync_q != vsync) begin
                        phase      <= adv_seq_pkg::ph_debug;
                        step       <= '0;
                        state      <= adv_seq_pkg::st_issue;
                        frame_tick <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* adv_seq_pkg.sv */
package adv_seq_pkg;

    // configuration phases, run top to bottom after reset
    typedef enum logic [2:0] {
        ph_bootstrap,
        ph_link_down,
        ph_init,
        ph_pll_check,
        ph_link_up,
        ph_debug,
        ph_ready
    } phase_t;

    // bus handshake states
    typedef enum logic [1:0] {
        st_issue,
        st_wait_1,
        st_wait_2,
        st_idle
    } state_t;

    typedef logic [4:0] step_t;
    typedef logic [9:0] frame_count_t;
    typedef logic [7:0] err_count_t;

    // lock flag inside register 0x9e
    localparam int PLL_LOCK_BIT = 4;

    // extra bits for the 0x16 write, zero selects 4:4:4 rgb output
    localparam adv_bus_pkg::reg_data_t OUTPUT_FMT = 8'h00;

    // debug readback, in the order the pass reads them
    localparam adv_bus_pkg::reg_addr_t REG_CHIP_REV     = 8'h00;
    localparam adv_bus_pkg::reg_addr_t REG_ID_HIGH      = 8'hF5;
    localparam adv_bus_pkg::reg_addr_t REG_ID_LOW       = 8'hF6;
    localparam adv_bus_pkg::reg_addr_t REG_PLL_STATUS   = 8'h9E;
    localparam adv_bus_pkg::reg_addr_t REG_VIC_DETECTED = 8'h3E;
    localparam adv_bus_pkg::reg_addr_t REG_VIC_TO_RX    = 8'h3D;
    localparam adv_bus_pkg::reg_addr_t REG_MISC         = 8'h42;

endpackage

/* adv_status_regs.sv */
`timescale 1ns/1ns

module adv_status_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       capture_en,
    input  adv_seq_pkg::step_t         capture_step,
    input  adv_bus_pkg::reg_data_t     i2c_data,
    input  logic                       pll_fail,
    input  logic                       frame_tick,
    output adv_bus_pkg::reg_data_t     chip_revision,
    output adv_bus_pkg::reg_data_t     id_check_high,
    output adv_bus_pkg::reg_data_t     id_check_low,
    output adv_bus_pkg::reg_data_t     pll_status,
    output adv_bus_pkg::reg_data_t     vic_detected,
    output adv_bus_pkg::reg_data_t     vic_to_rx,
    output adv_bus_pkg::reg_data_t     misc_data,
    output adv_seq_pkg::err_count_t    pll_errors,
    output adv_seq_pkg::frame_count_t  frame_count
);

    // capture_step is the index of the debug read, same order as the addresses
    always_ff @(posedge clk) begin
        if (capture_en) begin
            case (capture_step)
                5'd0:    chip_revision <= i2c_data;
                5'd1:    id_check_high <= i2c_data;
                5'd2:    id_check_low  <= i2c_data;
                5'd3:    pll_status    <= i2c_data;
                5'd4:    vic_detected  <= i2c_data;
                5'd5:    vic_to_rx     <= i2c_data;
                default: misc_data     <= i2c_data;
            endcase
        end
    end

    // both counters simply wrap
    always_ff @(posedge clk) begin
        if (!reset) begin
            pll_errors  <= '0;
            frame_count <= '0;
        end else begin
            if (pll_fail) begin
                pll_errors <= pll_errors + 8'd1;
            end
            if (frame_tick) begin
                frame_count <= frame_count + 10'd1;
            end
        end
    end

endmodule

/* flist.f */
adv_bus_pkg.sv
adv_seq_pkg.sv
adv_init_rom.sv
adv_seq_ctrl.sv
adv_status_regs.sv
adv7513_ctrl.sv
tb_clock_gen.sv
tb_adv7513_ctrl.sv

/* tb_adv7513_ctrl.sv */
`timescale 1ns/1ns

module tb_adv7513_ctrl;

    // first config 33, two debug passes 14, restart with one failed lock check 31 + 33
    localparam int TXN_COUNT       = 33 + 14 + 64;
    localparam int WATCHDOG_CYCLES = TXN_COUNT * 12 + 400;

    // one completed bus transaction as the master saw it
    typedef struct packed {
        adv_bus_pkg::chip_addr_t chip;
        adv_bus_pkg::reg_addr_t  addr;
        adv_bus_pkg::reg_data_t  value;
        logic                    is_read;
        logic                    ack_error;
        adv_bus_pkg::reg_data_t  data;
    } txn_t;

    logic                      clk;
    logic                      reset;
    logic                      hdmi_int;
    logic                      vsync;
    adv_bus_pkg::reg_data_t    cfg_reg_17;
    adv_bus_pkg::reg_data_t    cfg_reg_3b;
    adv_bus_pkg::reg_data_t    cfg_reg_3c;
    adv_bus_pkg::chip_addr_t   i2c_chip_addr;
    adv_bus_pkg::reg_addr_t    i2c_reg_addr;
    adv_bus_pkg::reg_data_t    i2c_value;
    logic                      i2c_is_read;
    logic                      i2c_enable;
    logic                      i2c_done;
    adv_bus_pkg::reg_data_t    i2c_data;
    logic                      i2c_ack_error;
    logic                      ready;
    adv_bus_pkg::reg_data_t    chip_revision;
    adv_bus_pkg::reg_data_t    id_check_high;
    adv_bus_pkg::reg_data_t    id_check_low;
    adv_bus_pkg::reg_data_t    pll_status;
    adv_bus_pkg::reg_data_t    vic_detected;
    adv_bus_pkg::reg_data_t    vic_to_rx;
    adv_bus_pkg::reg_data_t    misc_data;
    adv_seq_pkg::err_count_t   pll_errors;
    adv_seq_pkg::frame_count_t frame_count;

    txn_t                      txn_q[$];
    int                        pll_fail_budget;
    adv_seq_pkg::err_count_t   exp_errors;
    adv_seq_pkg::frame_count_t exp_frames;
    // expected writes with the register address in the upper byte
    logic [15:0]               cfg_list [0:31];

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    adv7513_ctrl u_adv7513_ctrl (.*);

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_error(input string msg);
        $display("** Error @ %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_addr(input string what, input adv_bus_pkg::reg_addr_t got,
                              input adv_bus_pkg::reg_addr_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
        end
    endtask

    task automatic check_data(input string what, input adv_bus_pkg::reg_data_t got,
                              input adv_bus_pkg::reg_data_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
        end
    endtask

    task automatic check_count(input adv_seq_pkg::err_count_t got_err,
                               input adv_seq_pkg::err_count_t exp_err,
                               input adv_seq_pkg::frame_count_t got_frames,
                               input adv_seq_pkg::frame_count_t exp_frames);
        if (got_err !== exp_err || got_frames !== exp_frames) begin
            report_error($sformatf("pll_errors %0d frame_count %0d, expected %0d and %0d",
                                   got_err, got_frames, exp_err, exp_frames));
        end
    endtask

    task automatic check_ready(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %0b, expected %0b", what, got, exp));
        end
    endtask

    task automatic check_dir(input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("direction: got is_read %0b, expected %0b", got, exp));
        end
    endtask

    // pops the next completed transaction, the same request again after an ack error
    task automatic expect_txn(input adv_bus_pkg::reg_addr_t addr,
                              input adv_bus_pkg::reg_data_t value,
                              input logic is_read, input logic exp_ready,
                              output adv_bus_pkg::reg_data_t data);
        txn_t txn;
        txn.ack_error = 1'b1;
        while (txn.ack_error) begin
            while (txn_q.size() == 0) begin
                next_cycle();
            end
            txn = txn_q.pop_front();
            check_addr("chip address", {1'b0, txn.chip}, 8'h39);
            check_addr("register address", txn.addr, addr);
            check_dir(txn.is_read, is_read);
            if (!is_read) begin
                check_data($sformatf("write value to 0x%02h", addr), txn.value, value);
            end
            check_ready("ready during transaction", ready, exp_ready);
        end
        data = txn.data;
    endtask

    // full configuration where the first lock_failures lock checks report no lock
    task automatic run_config(input int lock_failures);
        adv_bus_pkg::reg_data_t data;
        pll_fail_budget = lock_failures;
        for (int pass = 0; pass <= lock_failures; pass++) begin
            for (int i = 0; i < 30; i++) begin
                expect_txn(cfg_list[i][15:8], cfg_list[i][7:0], 1'b0, 1'b0, data);
                if (i == 0) begin
                    check_count(pll_errors, exp_errors, frame_count, exp_frames);
                end
            end
            expect_txn(adv_seq_pkg::REG_PLL_STATUS, 8'h00, 1'b1, 1'b0, data);
            if (!data[adv_seq_pkg::PLL_LOCK_BIT]) begin
                exp_errors = exp_errors + 8'd1;
            end
        end
        for (int i = 30; i < 32; i++) begin
            expect_txn(cfg_list[i][15:8], cfg_list[i][7:0], 1'b0, 1'b0, data);
        end
        // ready follows one cycle after the last write
        next_cycle();
        check_ready("ready after link-up", ready, 1'b1);
        check_count(pll_errors, exp_errors, frame_count, exp_frames);
    endtask

    // one vsync change, seven debug reads, then the captured bytes
    task automatic run_debug(input int lock_failures);
        adv_bus_pkg::reg_data_t data [0:6];
        adv_bus_pkg::reg_addr_t addrs [0:6];
        addrs = '{adv_seq_pkg::REG_CHIP_REV, adv_seq_pkg::REG_ID_HIGH,
                  adv_seq_pkg::REG_ID_LOW, adv_seq_pkg::REG_PLL_STATUS,
                  adv_seq_pkg::REG_VIC_DETECTED, adv_seq_pkg::REG_VIC_TO_RX,
                  adv_seq_pkg::REG_MISC};
        pll_fail_budget = lock_failures;
        vsync           = ~vsync;
        exp_frames      = exp_frames + 10'd1;
        for (int i = 0; i < 7; i++) begin
            expect_txn(addrs[i], 8'h00, 1'b1, 1'b1, data[i]);
        end
        if (!data[3][adv_seq_pkg::PLL_LOCK_BIT]) begin
            exp_errors = exp_errors + 8'd1;
        end
        // evaluation, capture, then back to idle
        repeat (3) next_cycle();
        check_data("chip_revision", chip_revision, data[0]);
        check_data("id_check_high", id_check_high, data[1]);
        check_data("id_check_low", id_check_low, data[2]);
        check_data("pll_status", pll_status, data[3]);
        check_data("vic_detected", vic_detected, data[4]);
        check_data("vic_to_rx", vic_to_rx, data[5]);
        check_data("misc_data", misc_data, data[6]);
        check_count(pll_errors, exp_errors, frame_count, exp_frames);
        check_ready("ready after debug pass", ready, 1'b1);
    endtask

    // bus master model that also draws the video config bytes from the same seed
    initial begin
        txn_t txn;
        int   delay;
        void'($urandom(32'hfaa386dc));
        cfg_reg_17    = 8'($urandom);
        cfg_reg_3b    = 8'($urandom);
        cfg_reg_3c    = 8'($urandom);
        i2c_done      = 1'b1;
        i2c_data      = 8'h00;
        i2c_ack_error = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (i2c_enable && i2c_done) begin
                txn.chip      = i2c_chip_addr;
                txn.addr      = i2c_reg_addr;
                txn.value     = i2c_value;
                txn.is_read   = i2c_is_read;
                i2c_done      = 1'b0;
                delay         = $urandom_range(8, 1);
                txn.ack_error = ($urandom_range(15, 0) == 0);
                txn.data      = 8'($urandom);
                if (txn.is_read && txn.addr == adv_seq_pkg::REG_PLL_STATUS) begin
                    txn.data[adv_seq_pkg::PLL_LOCK_BIT] = (pll_fail_budget == 0);
                    // a read lost to an ack error is not evaluated
                    if (!txn.ack_error && pll_fail_budget > 0) begin
                        pll_fail_budget--;
                    end
                end
                repeat (delay) @(posedge clk);
                #2;
                i2c_data      = txn.data;
                i2c_ack_error = txn.ack_error;
                i2c_done      = 1'b1;
                @(posedge clk);
                #1;
                txn_q.push_back(txn);
            end
        end
    end

    initial begin
        hdmi_int        = 1'b1;
        vsync           = 1'b0;
        pll_fail_budget = 0;
        exp_errors      = '0;
        exp_frames      = '0;
        @(posedge reset);
        check_ready("ready after reset", ready, 1'b0);
        check_ready("i2c_enable after reset", i2c_enable, 1'b0);
        check_count(pll_errors, exp_errors, frame_count, exp_frames);
        cfg_list = '{
            // bootstrap
            16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01, 16'hA2A4,
            16'hA3A4, 16'hE0D0, 16'hF900, 16'h94C0, 16'h96C0,
            // link power-down
            16'h4110, 16'hD610, 16'hA13C,
            // main init
            16'h1500, {8'h17, cfg_reg_17}, {8'h16, 8'h30 | adv_seq_pkg::OUTPUT_FMT},
            16'h5500, 16'h1846, 16'hAF06, 16'hBA60, 16'h0A00, 16'h0100,
            16'h0218, 16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10,
            {8'h3B, cfg_reg_3b}, {8'h3C, cfg_reg_3c},
            // link power-up after the lock check
            16'hA100, 16'hD600
        };
        run_config(0);
        run_debug(0);
        run_debug(1);
        // interrupt while idle, and the rerun meets one failed lock check
        hdmi_int = 1'b0;
        next_cycle();
        check_ready("ready after hdmi_int low", ready, 1'b0);
        hdmi_int = 1'b1;
        run_config(1);
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // active low for eight rising edges, released at the stimulus offset
    initial begin
        reset = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b1;
    end

endmodule
